// ==== Bender.yml ====
package:
  name: rs_station

sources:
  - src/rs_pkg.sv
  - src/rs_prio_sel.sv
  - src/rs_entry_array.sv
  - src/rs_issue_port.sv
  - src/rs_top.sv
  - target: test
    files:
      - bench/rs_tb.sv

// ==== bench/rs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_tb;

    localparam int DEPTH        = 8;
    localparam int DW           = 2;
    localparam int CW           = 2;
    localparam int NUM_ALU      = 2;
    localparam int NUM_MULT     = 1;
    localparam int RAND_CYCLES  = 400;
    localparam int DRAIN_CYCLES = 50;
    localparam int RUN_CYCLES   = 10 + 60 + RAND_CYCLES + DRAIN_CYCLES;
    localparam int NEVER        = 32'h7fff_ffff;

    logic                          clock = 1'b0;
    logic                          reset;
    rs_pkg::dispatch_t [DW-1:0]    dispatch;
    rs_pkg::cdb_t [CW-1:0]         cdb;
    rs_pkg::br_mask_t              new_branch;
    rs_pkg::br_task_e              br_task;
    rs_pkg::br_mask_t              rem_mask;
    logic [NUM_ALU-1:0]            alu_busy;
    logic [NUM_MULT-1:0]           mult_busy;
    rs_pkg::issue_t [NUM_ALU-1:0]  issued_alu;
    rs_pkg::issue_t [NUM_MULT-1:0] issued_mult;
    logic [$clog2(DW+1)-1:0]       open_entries;

    // reference model of outstanding instructions, keyed by pc
    rs_pkg::dispatch_t held[int unsigned];
    rs_pkg::br_mask_t  held_mask[int unsigned];
    int                eligible[int unsigned];
    int                issued_at[int unsigned];
    rs_pkg::br_mask_t  run_mask;
    int unsigned       next_pc;
    int unsigned       last_pc;
    int                step;
    int                mismatches;
    int                failures;

    always #50 clock = ~clock;

    rs_top dut_i (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .new_branch   (new_branch),
        .br_task      (br_task),
        .rem_mask     (rem_mask),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .issued_alu   (issued_alu),
        .issued_mult  (issued_mult),
        .open_entries (open_entries)
    );

    ////////////////////////////////////////////////////////////////////////////
    // back-pressure
    ////////////////////////////////////////////////////////////////////////////

    for (genvar u = 0; u < NUM_ALU; u++) begin : g_alu_hold
        alu_busy_idle: assert property (@(posedge clock) disable iff (reset)
            alu_busy[u] |=> !issued_alu[u].valid)
        else begin
            failures++;
            $display("busy ALU %0d received an instruction", u);
        end
    end

    mult_busy_idle: assert property (@(posedge clock) disable iff (reset)
        mult_busy[0] |=> !issued_mult[0].valid)
    else begin
        failures++;
        $display("busy multiplier received an instruction");
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks and model updates
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_eq(string name, longint unsigned exp, longint unsigned act);
        assert (exp == act) else begin
            mismatches++;
            $display("mismatch %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic expect_true(bit cond, string what);
        assert (cond) else begin
            failures++;
            $display("%s", what);
        end
    endtask

    task automatic check_issue(rs_pkg::issue_t pkt, rs_pkg::fu_class_e fu);
        int unsigned pc;

        pc = pkt.pc;
        if (!held.exists(pc)) begin
            expect_true(1'b0, $sformatf("issued pc %0h is not outstanding", pc));
        end else begin
            expect_eq("issue class", held[pc].fu, fu);
            expect_eq("issue dest", held[pc].dest, pkt.dest);
            expect_eq("issue src1", held[pc].src1.idx, pkt.src1);
            expect_eq("issue src2", held[pc].src2.idx, pkt.src2);
            expect_eq("issue mask", held_mask[pc], pkt.br_mask);
            expect_true(step >= eligible[pc],
                        $sformatf("pc %0h issued before its operands were ready", pc));
            issued_at[pc] = step;
            held.delete(pc);
            held_mask.delete(pc);
            eligible.delete(pc);
        end
    endtask

    function automatic int open_expected();
        return (DEPTH - held.num() < DW) ? DEPTH - held.num() : DW;
    endfunction

    // wait for the falling edge and check issues and room before idling the inputs
    task automatic next_cycle();
        run_mask = (run_mask | new_branch) & ~rem_mask;
        @(negedge clock);
        step++;
        for (int u = 0; u < NUM_ALU; u++) begin
            if (issued_alu[u].valid) begin
                check_issue(issued_alu[u], rs_pkg::FU_ALU);
            end
        end
        if (issued_mult[0].valid) begin
            check_issue(issued_mult[0], rs_pkg::FU_MULT);
        end
        expect_eq("open entries", open_expected(), open_entries);
        dispatch   = '0;
        cdb        = '0;
        new_branch = '0;
        br_task    = rs_pkg::BR_NONE;
        rem_mask   = '0;
    endtask

    task automatic wait_steps(int n);
        repeat (n) next_cycle();
    endtask

    task automatic send(int lane, rs_pkg::fu_class_e fu, bit rdy1, rs_pkg::preg_t idx1,
                        bit rdy2, rs_pkg::preg_t idx2);
        rs_pkg::dispatch_t d;

        d.valid      = 1'b1;
        d.fu         = fu;
        d.dest       = rs_pkg::preg_t'($urandom);
        d.src1.idx   = idx1;
        d.src1.ready = rdy1;
        d.src2.idx   = idx2;
        d.src2.ready = rdy2;
        d.pc         = next_pc;
        next_pc += 4;
        last_pc = d.pc;
        dispatch[lane] = d;
        held[d.pc] = d;
        // new entries carry the next-cycle branch mask
        held_mask[d.pc] = (run_mask | new_branch) & ~rem_mask;
        eligible[d.pc] = (rdy1 && rdy2) ? step + 2 : NEVER;
    endtask

    task automatic broadcast(int lane, rs_pkg::preg_t idx);
        rs_pkg::dispatch_t d;

        cdb[lane].valid = 1'b1;
        cdb[lane].preg  = idx;
        foreach (held[pc]) begin
            d = held[pc];
            if (d.src1.idx == idx) begin
                d.src1.ready = 1'b1;
            end
            if (d.src2.idx == idx) begin
                d.src2.ready = 1'b1;
            end
            if (d.src1.ready && d.src2.ready && eligible[pc] == NEVER) begin
                eligible[pc] = step + 2;
            end
            held[pc] = d;
        end
    endtask

    task automatic resolve(rs_pkg::br_task_e kind, rs_pkg::br_mask_t bits);
        int unsigned gone[$];

        br_task  = kind;
        rem_mask = bits;
        foreach (held_mask[pc]) begin
            if (kind == rs_pkg::BR_SQUASH && (held_mask[pc] & bits) != '0) begin
                gone.push_back(pc);
            end else if (kind == rs_pkg::BR_CLEAR) begin
                held_mask[pc] = held_mask[pc] & ~bits;
            end
        end
        foreach (gone[i]) begin
            held.delete(gone[i]);
            held_mask.delete(gone[i]);
            eligible.delete(gone[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int d;
        int n;
        int unsigned pc_a;
        int unsigned pc_b;
        int unsigned pc_keep;

        void'($urandom(32'h9f93));
        reset      = 1'b1;
        dispatch   = '0;
        cdb        = '0;
        new_branch = '0;
        br_task    = rs_pkg::BR_NONE;
        rem_mask   = '0;
        alu_busy   = '0;
        mult_busy  = '0;
        run_mask   = '0;
        next_pc    = 32'h1000;
        step       = 0;
        mismatches = 0;
        failures   = 0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int u = 0; u < NUM_ALU; u++) begin
            expect_eq("reset alu valid", 0, issued_alu[u].valid);
        end
        expect_eq("reset mult valid", 0, issued_mult[0].valid);
        expect_eq("reset open entries", DW, open_entries);

        // direct issue two edges after dispatch
        d = step;
        send(0, rs_pkg::FU_ALU, 1'b1, 6'd3, 1'b1, 6'd4);
        pc_a = last_pc;
        next_cycle();
        expect_true(!issued_at.exists(pc_a), "ALU instruction issued after a single edge");
        next_cycle();
        expect_eq("direct issue step", d + 2, issued_at.exists(pc_a) ? issued_at[pc_a] : -1);

        // wakeup of a waiting multiply
        send(0, rs_pkg::FU_MULT, 1'b1, 6'd5, 1'b0, 6'd33);
        pc_b = last_pc;
        wait_steps(5);
        expect_true(held.exists(pc_b), "multiply left the station before its wakeup");
        d = step;
        broadcast(0, 6'd33);
        wait_steps(3);
        expect_eq("wakeup issue step", d + 2, issued_at.exists(pc_b) ? issued_at[pc_b] : -1);

        // squash one branch and clear another before squashing the cleared bit
        new_branch = 4'b0001;
        send(0, rs_pkg::FU_ALU, 1'b0, 6'd20, 1'b1, 6'd1);
        pc_keep = last_pc;
        next_cycle();
        new_branch = 4'b0010;
        send(0, rs_pkg::FU_ALU, 1'b0, 6'd21, 1'b1, 6'd1);
        send(1, rs_pkg::FU_MULT, 1'b0, 6'd22, 1'b1, 6'd1);
        next_cycle();
        resolve(rs_pkg::BR_SQUASH, 4'b0010);
        next_cycle();
        resolve(rs_pkg::BR_CLEAR, 4'b0001);
        next_cycle();
        resolve(rs_pkg::BR_SQUASH, 4'b0001);
        next_cycle();
        broadcast(0, 6'd20);
        broadcast(1, 6'd21);
        next_cycle();
        broadcast(0, 6'd22);
        wait_steps(6);
        expect_true(issued_at.exists(pc_keep), "instruction on a cleared branch never issued");

        // random dispatch, wakeup and busy patterns
        for (int c = 0; c < RAND_CYCLES; c++) begin
            alu_busy  = NUM_ALU'($urandom);
            mult_busy = NUM_MULT'($urandom);
            n = $urandom % (open_expected() + 1);
            for (int l = 0; l < n; l++) begin
                send(l, rs_pkg::fu_class_e'(1'($urandom)), ($urandom % 4) != 0,
                     rs_pkg::preg_t'($urandom), ($urandom % 4) != 0,
                     rs_pkg::preg_t'($urandom));
            end
            for (int l = 0; l < CW; l++) begin
                if ($urandom % 2) begin
                    broadcast(l, rs_pkg::preg_t'($urandom));
                end
            end
            next_cycle();
        end

        // wake every register so the station drains
        alu_busy  = '0;
        mult_busy = '0;
        for (int p = 0; p < 64; p += 2) begin
            broadcast(0, rs_pkg::preg_t'(p));
            broadcast(1, rs_pkg::preg_t'(p + 1));
            next_cycle();
        end
        wait_steps(DEPTH + 4);
        expect_true(held.num() == 0, "instructions still held after draining");

        $display("mismatches: %0d, other errors: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(100.0 * (RUN_CYCLES + 200));
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/rs_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_entry_array #(
    parameter int DEPTH          = 8,
    parameter int DISPATCH_WIDTH = 2,
    parameter int CDB_WIDTH      = 2
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  rs_pkg::dispatch_t [DISPATCH_WIDTH-1:0] dispatch,
    input  logic [DISPATCH_WIDTH-1:0][DEPTH-1:0]   slot_gnt,
    input  rs_pkg::cdb_t [CDB_WIDTH-1:0]           cdb,
    input  rs_pkg::br_mask_t                       new_branch,
    input  rs_pkg::br_task_e                       br_task,
    input  rs_pkg::br_mask_t                       rem_mask,
    input  logic [DEPTH-1:0]                       alu_taken,
    input  logic [DEPTH-1:0]                       mult_taken,
    output logic [DEPTH-1:0]                       free_slots,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]    open_entries,
    output logic [DEPTH-1:0]                       alu_req,
    output logic [DEPTH-1:0]                       mult_req,
    output rs_pkg::rs_entry_t [DEPTH-1:0]          entries
);

    localparam int CNT_BITS  = $clog2(DEPTH + 1);
    localparam int OPEN_BITS = $clog2(DISPATCH_WIDTH + 1);

    rs_pkg::rs_entry_t [DEPTH-1:0] next_entries;
    rs_pkg::br_mask_t              run_mask;
    rs_pkg::br_mask_t              next_mask;
    logic [CNT_BITS-1:0]           num_entries;
    logic [CNT_BITS-1:0]           free_cnt;
    logic [DEPTH-1:0]              valid_vec;
    logic [DEPTH-1:0]              squash_vec;
    logic [DEPTH-1:0]              ready_vec;
    logic [DEPTH-1:0]              write_vec;
    logic [DEPTH-1:0]              taken_vec;
    logic [DISPATCH_WIDTH-1:0]     disp_valid;

    // set ready on any matching broadcast this cycle
    function automatic rs_pkg::tag_t wake(rs_pkg::tag_t tag,
                                          rs_pkg::cdb_t [CDB_WIDTH-1:0] bus);
        rs_pkg::tag_t woken;

        woken = tag;
        for (int c = 0; c < CDB_WIDTH; c++) begin
            if (bus[c].valid && bus[c].preg == tag.idx) begin
                woken.ready = 1'b1;
            end
        end
        return woken;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // requests and slot status from registered entries
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < DEPTH; s++) begin
            valid_vec[s]  = entries[s].inst.valid;
            squash_vec[s] = valid_vec[s] && (br_task == rs_pkg::BR_SQUASH) &&
                            |(entries[s].br_mask & rem_mask);
            // squashed slots never reach the selectors
            ready_vec[s]  = valid_vec[s] && entries[s].inst.src1.ready &&
                            entries[s].inst.src2.ready && !squash_vec[s];
            alu_req[s]    = ready_vec[s] && (entries[s].inst.fu == rs_pkg::FU_ALU);
            mult_req[s]   = ready_vec[s] && (entries[s].inst.fu == rs_pkg::FU_MULT);
        end
    end

    assign free_slots = ~valid_vec;
    assign taken_vec  = alu_taken | mult_taken;

    assign free_cnt     = CNT_BITS'(DEPTH) - num_entries;
    assign open_entries = (free_cnt > CNT_BITS'(DISPATCH_WIDTH)) ?
                          OPEN_BITS'(DISPATCH_WIDTH) : OPEN_BITS'(free_cnt);

    // running mask as seen by the next cycle
    assign next_mask = (run_mask | new_branch) & ~rem_mask;

    ////////////////////////////////////////////////////////////////////////////
    // next state of the slots
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_entries = entries;
        write_vec    = '0;

        for (int d = 0; d < DISPATCH_WIDTH; d++) begin
            disp_valid[d] = dispatch[d].valid;
        end

        for (int s = 0; s < DEPTH; s++) begin
            if (squash_vec[s]) begin
                next_entries[s].inst.valid = 1'b0;
            end
            if (br_task == rs_pkg::BR_CLEAR) begin
                next_entries[s].br_mask = entries[s].br_mask & ~rem_mask;
            end
            next_entries[s].inst.src1 = wake(entries[s].inst.src1, cdb);
            next_entries[s].inst.src2 = wake(entries[s].inst.src2, cdb);
            // issued this cycle
            if (taken_vec[s]) begin
                next_entries[s].inst.valid = 1'b0;
            end
        end

        // new instructions also see this cycle's broadcasts
        for (int d = 0; d < DISPATCH_WIDTH; d++) begin
            for (int s = 0; s < DEPTH; s++) begin
                if (dispatch[d].valid && slot_gnt[d][s]) begin
                    next_entries[s].inst      = dispatch[d];
                    next_entries[s].inst.src1 = wake(dispatch[d].src1, cdb);
                    next_entries[s].inst.src2 = wake(dispatch[d].src2, cdb);
                    next_entries[s].br_mask   = next_mask;
                    write_vec[s]              = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
        if (reset) begin
            run_mask    <= '0;
            num_entries <= '0;
            for (int s = 0; s < DEPTH; s++) begin
                entries[s].inst.valid <= 1'b0;
            end
        end else begin
            run_mask    <= next_mask;
            // taken and squashed slots are disjoint
            num_entries <= num_entries + CNT_BITS'($countones(write_vec))
                           - CNT_BITS'($countones(taken_vec))
                           - CNT_BITS'($countones(squash_vec));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // rename honours the reported room
    dispatch_fits: assert property (@(posedge clock) disable iff (reset)
        $countones(disp_valid) <= open_entries);

    take_write_disjoint: assert property (@(posedge clock) disable iff (reset)
        (taken_vec & write_vec) == '0);

    count_matches_slots: assert property (@(posedge clock) disable iff (reset)
        num_entries == CNT_BITS'($countones(valid_vec)));

endmodule

`default_nettype wire

// ==== src/rs_issue_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_port #(
    parameter int DEPTH = 8,
    parameter int UNITS = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [DEPTH-1:0]              req,
    input  logic [UNITS-1:0]              busy,
    input  rs_pkg::rs_entry_t [DEPTH-1:0] entries,
    output logic [DEPTH-1:0]              taken,
    output rs_pkg::issue_t [UNITS-1:0]    issued
);

    logic [UNITS-1:0][DEPTH-1:0] gnt;
    logic [UNITS-1:0][DEPTH-1:0] unit_sel;
    rs_pkg::issue_t [UNITS-1:0]  next_issue;

    rs_prio_sel #(
        .WIDTH  (DEPTH),
        .GRANTS (UNITS)
    ) issue_sel_i (
        .req (req),
        .gnt (gnt)
    );

    // hand grants out in order to the units that are free
    always_comb begin
        int g;

        g        = 0;
        unit_sel = '0;
        for (int u = 0; u < UNITS; u++) begin
            if (!busy[u]) begin
                unit_sel[u] = gnt[g];
                g++;
            end
        end
    end

    always_comb begin
        taken      = '0;
        next_issue = '0;
        for (int u = 0; u < UNITS; u++) begin
            taken = taken | unit_sel[u];
            for (int s = 0; s < DEPTH; s++) begin
                if (unit_sel[u][s]) begin
                    next_issue[u].valid   = 1'b1;
                    next_issue[u].dest    = entries[s].inst.dest;
                    next_issue[u].src1    = entries[s].inst.src1.idx;
                    next_issue[u].src2    = entries[s].inst.src2.idx;
                    next_issue[u].pc      = entries[s].inst.pc;
                    next_issue[u].br_mask = entries[s].br_mask;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        issued <= next_issue;
        if (reset) begin
            for (int u = 0; u < UNITS; u++) begin
                issued[u].valid <= 1'b0;
            end
        end
    end

    // a busy unit sees an idle packet one cycle later
    for (genvar u = 0; u < UNITS; u++) begin : g_busy_chk
        busy_holds_unit: assert property (@(posedge clock) disable iff (reset)
            busy[u] |=> !issued[u].valid);
    end

endmodule

`default_nettype wire

// ==== src/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    // physical register index width
    localparam int PREG_BITS = 6;

    // branches that may be in flight at once
    localparam int BR_SLOTS = 4;

    typedef logic [PREG_BITS-1:0] preg_t;

    // one bit per unresolved branch
    typedef logic [BR_SLOTS-1:0] br_mask_t;

    ////////////////////////////////////////////////////////////////////////////
    // enums
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_class_e;

    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_SQUASH = 2'd1,
        BR_CLEAR  = 2'd2
    } br_task_e;

    ////////////////////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////////////////////

    // source operand as seen by rename
    typedef struct packed {
        preg_t idx;
        logic  ready;
    } tag_t;

    typedef struct packed {
        logic        valid;
        fu_class_e   fu;
        preg_t       dest;
        tag_t        src1;
        tag_t        src2;
        logic [31:0] pc;
    } dispatch_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
    } cdb_t;

    // stored slot holding the dispatched packet and its older branches
    typedef struct packed {
        dispatch_t inst;
        br_mask_t  br_mask;
    } rs_entry_t;

    typedef struct packed {
        logic        valid;
        preg_t       dest;
        preg_t       src1;
        preg_t       src2;
        logic [31:0] pc;
        br_mask_t    br_mask;
    } issue_t;

endpackage

`default_nettype wire

// ==== src/rs_prio_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

// lowest-index-first selector with several grant channels
module rs_prio_sel #(
    parameter int WIDTH  = 8,
    parameter int GRANTS = 2
) (
    input  logic [WIDTH-1:0]              req,
    output logic [GRANTS-1:0][WIDTH-1:0]  gnt
);

    ////////////////////////////////////////////////////////////////////////////
    // grant peeling
    ////////////////////////////////////////////////////////////////////////////

    // channel 0 takes the lowest request, channel 1 the next one, and so on.
    // every channel strips its own grant before the next one looks.
    always_comb begin
        logic [WIDTH-1:0] remaining;

        remaining = req;
        for (int g = 0; g < GRANTS; g++) begin
            // isolate lowest set bit
            gnt[g] = remaining & (~remaining + WIDTH'(1));
            remaining = remaining & ~gnt[g];
        end
    end

endmodule

`default_nettype wire

// ==== src/rs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top #(
    parameter int DEPTH          = 8,
    parameter int DISPATCH_WIDTH = 2,
    parameter int CDB_WIDTH      = 2,
    parameter int NUM_ALU        = 2,
    parameter int NUM_MULT       = 1
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  rs_pkg::dispatch_t [DISPATCH_WIDTH-1:0] dispatch,
    input  rs_pkg::cdb_t [CDB_WIDTH-1:0]           cdb,
    input  rs_pkg::br_mask_t                       new_branch,
    input  rs_pkg::br_task_e                       br_task,
    input  rs_pkg::br_mask_t                       rem_mask,
    input  logic [NUM_ALU-1:0]                     alu_busy,
    input  logic [NUM_MULT-1:0]                    mult_busy,
    output rs_pkg::issue_t [NUM_ALU-1:0]           issued_alu,
    output rs_pkg::issue_t [NUM_MULT-1:0]          issued_mult,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0]    open_entries
);

    logic [DEPTH-1:0]                     free_slots;
    logic [DISPATCH_WIDTH-1:0][DEPTH-1:0] slot_gnt;
    logic [DEPTH-1:0]                     alu_req;
    logic [DEPTH-1:0]                     mult_req;
    logic [DEPTH-1:0]                     alu_taken;
    logic [DEPTH-1:0]                     mult_taken;
    rs_pkg::rs_entry_t [DEPTH-1:0]        entries;

    // lowest free slots go to the lowest dispatch lanes
    rs_prio_sel #(
        .WIDTH  (DEPTH),
        .GRANTS (DISPATCH_WIDTH)
    ) alloc_sel_i (
        .req (free_slots),
        .gnt (slot_gnt)
    );

    rs_entry_array #(
        .DEPTH          (DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .CDB_WIDTH      (CDB_WIDTH)
    ) array_i (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .slot_gnt     (slot_gnt),
        .cdb          (cdb),
        .new_branch   (new_branch),
        .br_task      (br_task),
        .rem_mask     (rem_mask),
        .alu_taken    (alu_taken),
        .mult_taken   (mult_taken),
        .free_slots   (free_slots),
        .open_entries (open_entries),
        .alu_req      (alu_req),
        .mult_req     (mult_req),
        .entries      (entries)
    );

    rs_issue_port #(
        .DEPTH (DEPTH),
        .UNITS (NUM_ALU)
    ) alu_port_i (
        .clock   (clock),
        .reset   (reset),
        .req     (alu_req),
        .busy    (alu_busy),
        .entries (entries),
        .taken   (alu_taken),
        .issued  (issued_alu)
    );

    rs_issue_port #(
        .DEPTH (DEPTH),
        .UNITS (NUM_MULT)
    ) mult_port_i (
        .clock   (clock),
        .reset   (reset),
        .req     (mult_req),
        .busy    (mult_busy),
        .entries (entries),
        .taken   (mult_taken),
        .issued  (issued_mult)
    );

endmodule

`default_nettype wire

// ==== vlog.f ====
src/rs_pkg.sv
src/rs_prio_sel.sv
src/rs_entry_array.sv
src/rs_issue_port.sv
src/rs_top.sv
bench/rs_tb.sv
